//--- lsu_types_pkg.sv
`default_nettype none

package lsu_types_pkg;

	//////////////////////////////////////////////////
	// core side widths

	typedef logic [31:0] addr_t; // byte address
	typedef logic [31:0] word_t; // one register value

	//////////////////////////////////////////////////
	// access codes

	// loads, taken straight from the funct3 field
	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} funct3_t;

	localparam funct3_t sb = lb; // stores reuse the signed load encodings
	localparam funct3_t sh = lh;
	localparam funct3_t sw = lw;

	//////////////////////////////////////////////////
	// request from the execute stage

	typedef struct packed {
		funct3_t funct3;
		word_t   src1; // base register
		word_t   src2; // store data
		word_t   imm;  // offset, already sign extended
	} lsu_req_t;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

	//////////////////////////////////////////////////
	// field types

	typedef logic [63:0] dword_t;    // one data beat
	typedef logic [7:0]  strb_t;     // one bit per byte lane
	typedef logic [2:0]  axi_size_t; // log2 of the access bytes
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;

	//////////////////////////////////////////////////
	// channel payloads

	// address channel, shared by ar and aw
	typedef struct packed {
		lsu_types_pkg::addr_t addr;
		axi_size_t            size;
	} axi_ar_t;

	typedef struct packed {
		dword_t    data;
		axi_resp_t resp;
	} axi_r_t;

	typedef struct packed {
		dword_t data;
		strb_t  strb; // lanes that the slave must write
	} axi_w_t;

	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

endpackage

`default_nettype wire

//--- lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
	input  lsu_types_pkg::addr_t   addr,
	input  lsu_types_pkg::funct3_t funct3,
	input  axi_pkg::dword_t        rdata,
	output lsu_types_pkg::word_t   value
);
	import lsu_types_pkg::*;

	word_t half;
	word_t shifted;

	//////////////////////////////////////////////////
	// lane select

	always_comb begin
		half    = addr[2] ? rdata[63:32] : rdata[31:0]; // bit 2 picks the word
		shifted = half >> {addr[1:0], 3'b000};           // addressed byte to lane 0
	end

	//////////////////////////////////////////////////
	// extension

	always_comb begin
		case (funct3)
			lb: begin
				value = {{24{shifted[7]}}, shifted[7:0]};
			end
			lh: begin
				value = {{16{shifted[15]}}, shifted[15:0]};
			end
			lw: begin
				value = shifted;
			end
			lbu: begin
				value = {24'b0, shifted[7:0]};
			end
			lhu: begin
				value = {16'b0, shifted[15:0]};
			end
			default: begin
				value = '0; // not a load code
			end
		endcase
	end

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  logic                    clock,
	input  logic                    reset,

	input  lsu_types_pkg::lsu_req_t req,
	input  logic                    ren,
	input  logic                    wen,
	input  logic                    wb_valid,

	output axi_pkg::axi_ar_t        ar,
	output logic                    arvalid,
	input  logic                    arready,
	input  axi_pkg::axi_r_t         r,
	input  logic                    rvalid,
	output logic                    rready,

	output axi_pkg::axi_ar_t        aw,
	output logic                    awvalid,
	input  logic                    awready,
	output axi_pkg::axi_w_t         w,
	output logic                    wvalid,
	input  logic                    wready,
	input  axi_pkg::axi_b_t         b,
	input  logic                    bvalid,
	output logic                    bready,

	output lsu_types_pkg::word_t    lsu_val,
	output logic                    load_done,
	output logic                    store_done
);
	import lsu_types_pkg::*;
	import axi_pkg::*;

	addr_t     addr;
	axi_size_t size;
	strb_t     mask;
	strb_t     strb;
	dword_t    wdata;
	word_t     load_value;
	logic      r_fire;
	logic      b_fire;

	//////////////////////////////////////////////////
	// address and store lanes

	assign addr = req.src1 + req.imm;
	assign size = {1'b0, req.funct3[1:0]};

	assign ar = '{addr: addr, size: size};
	assign aw = '{addr: addr, size: size};

	always_comb begin
		case (req.funct3)
			sb:      mask = 8'h01;
			sh:      mask = 8'h03;
			sw:      mask = 8'h0f;
			default: mask = 8'h00;
		endcase
	end

	assign strb  = mask << addr[2:0];                         // move the mask to the addressed lane
	assign wdata = {32'b0, req.src2} << {addr[2:0], 3'b000}; // data follows the strobes
	assign w     = '{data: wdata, strb: strb};

	//////////////////////////////////////////////////
	// responses

	assign rready = 1'b1; // the core never stalls a response
	assign bready = 1'b1;

	assign r_fire = rvalid & rready;
	assign b_fire = bvalid & bready;

	assign store_done = b_fire & (b.resp == resp_okay); // a failed write stays pending

	lsu_load_align u_load_align (
		.addr   (addr),
		.funct3 (req.funct3),
		.rdata  (r.data),
		.value  (load_value)
	);

	//////////////////////////////////////////////////
	// channel valids and load result

	always_ff @(posedge clock) begin
		if (reset) begin
			arvalid   <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			lsu_val   <= '0;
			load_done <= 1'b0;
		end else begin
			arvalid   <= arvalid ? ~arready : ren; // set by the strobe, held until taken
			awvalid   <= awvalid ? ~awready : wen;
			wvalid    <= wvalid ? ~wready : wen;   // independent of aw
			load_done <= r_fire & (r.resp == resp_okay);
			if (wb_valid) begin
				lsu_val <= '0; // writeback consumed the value
			end else if (r_fire) begin
				lsu_val <= load_value;
			end
		end
	end

endmodule

`default_nettype wire

//--- axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
	parameter int MEM_WORDS     = 512,
	parameter int READ_LATENCY  = 2,
	parameter int WRITE_LATENCY = 1
) (
	input  logic             clock,
	input  logic             reset,

	input  axi_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready,
	output axi_pkg::axi_r_t  r,
	output logic             rvalid,
	input  logic             rready,

	input  axi_pkg::axi_ar_t aw,
	input  logic             awvalid,
	output logic             awready,
	input  axi_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready,
	output axi_pkg::axi_b_t  b,
	output logic             bvalid,
	input  logic             bready
);
	import lsu_types_pkg::*;
	import axi_pkg::*;

	localparam addr_t mem_base = 32'h8000_0000;
	localparam int    idx_w    = $clog2(MEM_WORDS);
	localparam int    max_lat  = (READ_LATENCY > WRITE_LATENCY) ? READ_LATENCY : WRITE_LATENCY;
	localparam int    lat_w    = $clog2(max_lat + 1);

	typedef logic [idx_w-1:0] idx_t;
	typedef logic [lat_w-1:0] lat_t;

	typedef enum logic [2:0] {
		idle,
		read_wait,
		read_resp,
		write_collect,
		write_wait,
		write_resp
	} state_t;

	state_t state;
	lat_t   lat_cnt;
	logic   aw_taken;
	logic   w_taken;
	logic   ar_fire;
	logic   aw_fire;
	logic   w_fire;
	logic   both_in;
	logic   do_write;
	dword_t rdata_q;
	addr_t  aw_addr_q;
	axi_w_t w_q;
	addr_t  wr_addr;
	axi_w_t wr_beat;
	idx_t   wr_idx;
	dword_t mem [MEM_WORDS];

	function automatic idx_t to_index(addr_t a);
		addr_t offset;
		offset = a - mem_base;
		return offset[idx_w+2:3]; // one entry per doubleword
	endfunction

	//////////////////////////////////////////////////
	// handshakes

	assign arready = (state == idle);
	assign awready = (state == idle) | ((state == write_collect) & ~aw_taken);
	assign wready  = (state == idle) | ((state == write_collect) & ~w_taken);

	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;

	assign both_in  = (aw_taken | aw_fire) & (w_taken | w_fire);
	assign do_write = ((state == idle) | (state == write_collect)) & both_in & ~ar_fire;

	assign wr_addr = aw_fire ? aw.addr : aw_addr_q; // the late channel comes straight from the bus
	assign wr_beat = w_fire ? w : w_q;
	assign wr_idx  = to_index(wr_addr);

	assign rvalid = (state == read_resp);
	assign bvalid = (state == write_resp);
	assign r      = '{data: rdata_q, resp: resp_okay};
	assign b      = '{resp: resp_okay};

	//////////////////////////////////////////////////
	// control

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= idle;
			lat_cnt  <= '0;
			aw_taken <= 1'b0;
			w_taken  <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (ar_fire) begin
						if (READ_LATENCY == 1) begin
							state <= read_resp;
						end else begin
							state   <= read_wait;
							lat_cnt <= lat_t'(READ_LATENCY - 2);
						end
					end else if (do_write) begin
						state   <= write_wait;
						lat_cnt <= lat_t'(WRITE_LATENCY - 1);
					end else if (aw_fire | w_fire) begin
						state    <= write_collect; // wait for the other channel
						aw_taken <= aw_fire;
						w_taken  <= w_fire;
					end
				end
				read_wait: begin
					if (lat_cnt == '0) state <= read_resp;
					else lat_cnt <= lat_cnt - 1'b1;
				end
				read_resp: begin
					if (rready) state <= idle;
				end
				write_collect: begin
					if (do_write) begin
						state    <= write_wait;
						lat_cnt  <= lat_t'(WRITE_LATENCY - 1);
						aw_taken <= 1'b0;
						w_taken  <= 1'b0;
					end
				end
				write_wait: begin
					if (lat_cnt == '0) state <= write_resp;
					else lat_cnt <= lat_cnt - 1'b1;
				end
				write_resp: begin
					if (bready) state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// array and payload

	always_ff @(posedge clock) begin
		if (ar_fire) rdata_q <= mem[to_index(ar.addr)]; // read once, then only delayed
		if (aw_fire) aw_addr_q <= aw.addr;
		if (w_fire) w_q <= w;
		if (do_write) begin
			for (int i = 0; i < 8; i++) begin
				if (wr_beat.strb[i]) mem[wr_idx][i*8 +: 8] <= wr_beat.data[i*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int MEM_WORDS     = 512,
	parameter int READ_LATENCY  = 2,
	parameter int WRITE_LATENCY = 1
) (
	input  logic                    clock,
	input  logic                    reset,
	input  lsu_types_pkg::lsu_req_t req,
	input  logic                    ren,
	input  logic                    wen,
	input  logic                    wb_valid,
	output lsu_types_pkg::word_t    lsu_val,
	output logic                    load_done,
	output logic                    store_done
);
	import axi_pkg::*;

	axi_ar_t ar;
	logic    arvalid;
	logic    arready;
	axi_r_t  r;
	logic    rvalid;
	logic    rready;
	axi_ar_t aw;
	logic    awvalid;
	logic    awready;
	axi_w_t  w;
	logic    wvalid;
	logic    wready;
	axi_b_t  b;
	logic    bvalid;
	logic    bready;

	//////////////////////////////////////////////////
	// master

	lsu u_lsu (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.ren        (ren),
		.wen        (wen),
		.wb_valid   (wb_valid),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.b          (b),
		.bvalid     (bvalid),
		.bready     (bready),
		.lsu_val    (lsu_val),
		.load_done  (load_done),
		.store_done (store_done)
	);

	//////////////////////////////////////////////////
	// memory

	axi_sram #(
		.MEM_WORDS     (MEM_WORDS),
		.READ_LATENCY  (READ_LATENCY),
		.WRITE_LATENCY (WRITE_LATENCY)
	) u_sram (
		.clock   (clock),
		.reset   (reset),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

`default_nettype wire

//--- lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
	input logic             clock,
	input logic             reset,
	input logic             ren,
	input logic             wen,
	input logic             load_done,
	input logic             store_done,
	input axi_pkg::axi_ar_t ar,
	input logic             arvalid,
	input logic             arready,
	input axi_pkg::axi_ar_t aw,
	input logic             awvalid,
	input logic             awready,
	input axi_pkg::axi_w_t  w,
	input logic             wvalid,
	input logic             wready
);

	//////////////////////////////////////////////////
	// valid holds with a stable payload until ready

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("arvalid or ar changed before arready");

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("awvalid or aw changed before awready");

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(w))
		else $error("wvalid or w changed before wready");

	//////////////////////////////////////////////////
	// core side

	strobes_apart: assert property (@(posedge clock) disable iff (reset) !(ren && wen))
		else $error("ren and wen high in the same cycle");

	done_apart: assert property (@(posedge clock) disable iff (reset)
		!(load_done && store_done))
		else $error("load_done and store_done high in the same cycle");

endmodule

bind lsu_top lsu_asserts u_asserts (
	.clock      (clock),
	.reset      (reset),
	.ren        (ren),
	.wen        (wen),
	.load_done  (load_done),
	.store_done (store_done),
	.ar         (ar),
	.arvalid    (arvalid),
	.arready    (arready),
	.aw         (aw),
	.awvalid    (awvalid),
	.awready    (awready),
	.w          (w),
	.wvalid     (wvalid),
	.wready     (wready)
);

`default_nettype wire

//--- tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
	import lsu_types_pkg::*;

	localparam int max_records    = 64;
	localparam int fields         = 6; // op funct3 src1 imm src2 expected
	localparam int timeout_cycles = 50;

	localparam logic [31:0] op_store = 32'h1;
	localparam logic [31:0] op_load  = 32'h2;
	localparam logic [31:0] op_clear = 32'h3;

	logic        clock;
	logic        reset;
	lsu_req_t    req;
	logic        ren;
	logic        wen;
	logic        wb_valid;
	word_t       lsu_val;
	logic        load_done;
	logic        store_done;
	logic [31:0] testdata [max_records*fields];
	logic        run_ended;

	lsu_top dut (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.ren        (ren),
		.wen        (wen),
		.wb_valid   (wb_valid),
		.lsu_val    (lsu_val),
		.load_done  (load_done),
		.store_done (store_done)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	//////////////////////////////////////////////////
	// helpers

	task automatic fail_run(input string why);
		run_ended = 1'b1;
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR: %s expected %08h actual %08h", name, expected, actual));
		end
	endtask

	// one strobe cycle, called on a falling edge
	task automatic start_access(input lsu_req_t access, input logic is_load);
		req = access;
		ren = is_load;
		wen = ~is_load;
		@(negedge clock);
		ren = 1'b0;
		wen = 1'b0;
	endtask

	task automatic wait_done(input string name, input logic is_load);
		int cycles;
		cycles = 0;
		while ((is_load ? load_done : store_done) !== 1'b1) begin
			if ((is_load ? store_done : load_done) === 1'b1) begin
				fail_run($sformatf("%s finished with the wrong done signal", name));
			end
			if (cycles >= timeout_cycles) begin
				fail_run($sformatf("%s got no done signal within %0d cycles", name, timeout_cycles));
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		lsu_req_t    access;
		word_t       expected;
		logic [31:0] op;
		string       name;
		int          idx;
		run_ended = 1'b0;
		reset     = 1'b1;
		req       = '0;
		ren       = 1'b0;
		wen       = 1'b0;
		wb_valid  = 1'b0;
		for (int i = 0; i < max_records*fields; i++) begin
			testdata[i] = '0; // an op of zero ends the list
		end
		$readmemh("lsu_testdata.txt", testdata);

		repeat (16) @(negedge clock);
		reset = 1'b0;

		for (int c = 0; c < 4; c++) begin
			@(negedge clock);
			check("reset lsu_val", '0, lsu_val);
			check("reset load_done", '0, {31'b0, load_done});
			check("reset store_done", '0, {31'b0, store_done});
		end

		idx = 0;
		while (idx < max_records && testdata[idx*fields] != '0) begin
			op            = testdata[idx*fields];
			access.funct3 = funct3_t'(testdata[idx*fields+1][2:0]);
			access.src1   = testdata[idx*fields+2];
			access.imm    = testdata[idx*fields+3];
			access.src2   = testdata[idx*fields+4];
			expected      = testdata[idx*fields+5];
			name = $sformatf("record %0d op %0d funct3 %0d", idx, op, access.funct3);
			case (op)
				op_store: begin
					start_access(access, 1'b0);
					wait_done(name, 1'b0);
				end
				op_load: begin
					start_access(access, 1'b1);
					wait_done(name, 1'b1);
					check(name, expected, lsu_val); // value stays until writeback
				end
				op_clear: begin
					wb_valid = 1'b1;
					@(negedge clock);
					wb_valid = 1'b0;
					check(name, expected, lsu_val);
				end
				default: begin
					fail_run($sformatf("record %0d has an unknown op %0h", idx, op));
				end
			endcase
			@(negedge clock);
			idx++;
		end

		if (idx == 0) begin
			fail_run("no records were read from lsu_testdata.txt");
		end else begin
			run_ended = 1'b1;
			$display("Result: PASSED");
			$finish;
		end
	end

	// an assertion can end the run without passing through the tasks above
	final begin
		if (!run_ended) begin
			$display("Result: FAILED");
		end
	end

endmodule

`default_nettype wire

//--- lsu_testdata.txt
// op funct3 src1 imm src2 expected, all hex
// op 1 store, 2 load, 3 clear; funct3 0 b, 1 h, 2 w, 4 bu, 5 hu
1 2 80000100 00000000 11223344 00000000
1 2 80000100 00000004 55667788 00000000
2 2 80000100 00000000 00000000 11223344
2 2 80000100 00000004 00000000 55667788
1 2 80000200 00000000 00000000 00000000
1 2 80000200 00000004 ffffffff 00000000
1 0 80000200 00000000 123456a1 00000000
1 0 80000200 00000001 ffffffb2 00000000
1 0 80000200 00000002 000000c3 00000000
1 0 80000200 00000003 aaaaaad4 00000000
2 2 80000200 00000000 00000000 d4c3b2a1
1 1 80000200 00000005 00005566 00000000
1 0 80000200 00000007 aaaaaa12 00000000
1 0 80000200 00000004 00000077 00000000
2 2 80000200 00000004 00000000 12556677
2 0 80000200 00000000 00000000 ffffffa1
2 4 80000200 00000001 00000000 000000b2
2 0 80000200 00000002 00000000 ffffffc3
2 4 80000200 00000003 00000000 000000d4
2 0 80000200 00000004 00000000 00000077
2 4 80000200 00000005 00000000 00000066
2 0 80000200 00000006 00000000 00000055
2 4 80000200 00000007 00000000 00000012
2 1 80000200 00000000 00000000 ffffb2a1
2 5 80000200 00000002 00000000 0000d4c3
2 1 80000200 00000001 00000000 ffffc3b2
2 1 80000200 00000006 00000000 00001255
2 5 80000200 00000004 00000000 00006677
3 0 00000000 00000000 00000000 00000000
2 2 80000300 ffffff04 00000000 12556677
2 0 80000210 fffffff5 00000000 00000066
1 2 80000400 fffffe00 cafef00d 00000000
2 2 80000000 00000200 00000000 cafef00d
3 0 00000000 00000000 00000000 00000000

//--- verilog.f
lsu_types_pkg.sv
axi_pkg.sv
lsu_load_align.sv
lsu.sv
axi_sram.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lsu testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
	-f verilog.f -o tb_lsu_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_lsu_top_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
